// File: project.f
rtl/systolic_pkg.sv
rtl/mm_ctrl_pkg.sv
rtl/slice_loader.sv
rtl/systolic_pe.sv
rtl/systolic_array.sv
rtl/mm_controller.sv
rtl/mm_top.sv
sim/slice_source.sv
sim/mm_tb.sv

// File: Makefile
# Verilator build and run of the matrix-multiply engine testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f project.f --top-module mm_tb -Mdir obj_dir -o mm_tb
	@out=$$(./obj_dir/mm_tb); echo "$$out"; \
		echo "$$out" | grep -q "^Finished with no errors$$"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f project.f --top-module mm_tb

clean:
	rm -rf obj_dir

// File: sim/mm_input.hex
// first word is the case count, then per case one line of A and one of B (8-bit, row-major)
// followed by two lines of expected C (32-bit, row-major)
00000005
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01
05 fd 07 7f 80 02 ff 0a 00 01 fe 03 64 ce 19 f9
00000005 fffffffd 00000007 0000007f ffffff80 00000002 ffffffff 0000000a
00000000 00000001 fffffffe 00000003 00000064 ffffffce 00000019 fffffff9
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000
7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200
ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200 ffff0200
01 02 03 04 ff fe fd fc 00 01 00 ff 0a f6 14 ec
01 00 ff 02 03 01 00 fe ff 02 01 00 00 fd 04 01
00000004 fffffffc 00000012 00000002 fffffffc 00000004 ffffffee fffffffe
00000003 00000004 fffffffc fffffffd ffffffd8 0000005a ffffffba 00000014
02 00 00 00 00 ff 00 00 00 00 03 00 00 00 00 80
01 02 03 04 ff fe fd fc 00 01 00 ff 0a f6 14 ec
00000002 00000004 00000006 00000008 00000001 00000002 00000003 00000004
00000000 00000003 00000000 fffffffd fffffb00 00000500 fffff600 00000a00

// File: sim/mm_tb.sv
// matrix-multiply testbench: slice streams from a vector file, result checks under back-pressure
`timescale 1ns/100ps
`default_nettype none

module mm_tb;

    import systolic_pkg::*;

    localparam int MAX_CASES  = 8;
    localparam int CASE_WORDS = 3 * MTRX_ELEMS;
    localparam int WAIT_LIMIT = 1000;

    logic s_clk;
    logic s_rst;
    logic a_valid;
    logic b_valid;
    logic a_ready;
    logic b_ready;
    logic c_valid;
    logic c_ready;
    elem_t a_data;
    elem_t b_data;
    acc_t  c_data;

    logic a_start;
    logic b_start;
    logic a_src_idle;
    logic b_src_idle;
    logic a_src_timeout;
    logic b_src_timeout;
    elem_t [MTRX_ELEMS-1:0] a_src_mtrx;
    elem_t [MTRX_ELEMS-1:0] b_src_mtrx;

    // case count, then A, B and expected C per case
    logic [31:0] vec_mem [0:1+MAX_CASES*CASE_WORDS-1];

    mm_top uut (
        .s_clk   (s_clk),
        .s_rst   (s_rst),
        .a_valid (a_valid),
        .a_data  (a_data),
        .a_ready (a_ready),
        .b_valid (b_valid),
        .b_data  (b_data),
        .b_ready (b_ready),
        .c_valid (c_valid),
        .c_data  (c_data),
        .c_ready (c_ready)
    );

    slice_source #(.LFSR_SKIP(11)) u_a_src (
        .s_clk         (s_clk),
        .start         (a_start),
        .mtrx          (a_src_mtrx),
        .idle          (a_src_idle),
        .ready_timeout (a_src_timeout),
        .valid         (a_valid),
        .data          (a_data),
        .ready         (a_ready)
    );

    slice_source #(.LFSR_SKIP(23)) u_b_src (
        .s_clk         (s_clk),
        .start         (b_start),
        .mtrx          (b_src_mtrx),
        .idle          (b_src_idle),
        .ready_timeout (b_src_timeout),
        .valid         (b_valid),
        .data          (b_data),
        .ready         (b_ready)
    );

    initial begin
        s_clk = 1'b0;
        forever #2 s_clk = ~s_clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("Finished with errors");
        $fatal(1, "wait expired");
    endtask

    always @(posedge s_clk) begin
        if (a_src_timeout || b_src_timeout) begin
            report_timeout(a_src_timeout ? "A stream waited too long for a_ready"
                                         : "B stream waited too long for b_ready");
        end
    end

    // hands each case to both sources as soon as they are idle, no wait for results
    task automatic send_cases(input int n_cases);
        int base;
        int wait_cycles;
        for (int c = 0; c < n_cases; c++) begin
            base        = 1 + c * CASE_WORDS;
            wait_cycles = 0;
            @(posedge s_clk);
            while (!(a_src_idle && b_src_idle)) begin
                wait_cycles++;
                if (wait_cycles > WAIT_LIMIT) begin
                    report_timeout("slice sources stayed busy");
                end
                @(posedge s_clk);
            end
            #1;
            for (int k = 0; k < MTRX_ELEMS; k++) begin
                a_src_mtrx[k] = vec_mem[base + k][7:0];
                b_src_mtrx[k] = vec_mem[base + MTRX_ELEMS + k][7:0];
            end
            a_start = 1'b1;
            b_start = 1'b1;
            @(posedge s_clk);
            #1;
            a_start = 1'b0;
            b_start = 1'b0;
        end
    endtask

    task automatic collect_results(input int n_cases);
        logic [31:0] lfsr;
        logic        hold_pending;
        acc_t        held;
        int          base;
        int          beat;
        int          idle_cycles;
        lfsr         = 32'ha3db_dd67;
        hold_pending = 1'b0;
        held         = '0;
        for (int c = 0; c < n_cases; c++) begin
            base        = 1 + c * CASE_WORDS + 2 * MTRX_ELEMS;
            beat        = 0;
            idle_cycles = 0;
            while (beat < MTRX_ELEMS) begin
                @(posedge s_clk);
                #1;
                lfsr    = lfsr_step(lfsr);
                c_ready = lfsr[0];
                // result refused last cycle must still be offered unchanged
                if (hold_pending) begin
                    check_value("c_valid", 32'(c_valid), 32'd1);
                    check_value("c_data", c_data, held);
                    hold_pending = 1'b0;
                end
                if (c_valid && c_ready) begin
                    check_value($sformatf("c_data case %0d beat %0d", c, beat),
                                c_data, vec_mem[base + beat]);
                    beat++;
                    idle_cycles = 0;
                end else begin
                    if (c_valid) begin
                        held         = c_data;
                        hold_pending = 1'b1;
                    end
                    idle_cycles++;
                    if (idle_cycles > WAIT_LIMIT) begin
                        report_timeout("no result transfer while waiting for c_valid");
                    end
                end
            end
        end
    endtask

    initial begin
        int n_cases;
        s_rst      = 1'b1;
        c_ready    = 1'b0;
        a_start    = 1'b0;
        b_start    = 1'b0;
        a_src_mtrx = '0;
        b_src_mtrx = '0;
        $readmemh("sim/mm_input.hex", vec_mem);
        n_cases = int'(vec_mem[0]);
        if (n_cases < 1 || n_cases > MAX_CASES) begin
            $display("test data holds no usable case count");
            $display("Finished with errors");
            $fatal(1, "bad test data");
        end
        repeat (2) @(posedge s_clk);
        #1;
        s_rst = 1'b0;
        @(posedge s_clk);
        #1;
        check_value("c_valid", 32'(c_valid), 32'd0);
        check_value("a_ready", 32'(a_ready), 32'd1);
        check_value("b_ready", 32'(b_ready), 32'd1);
        fork
            send_cases(n_cases);
        join_none
        collect_results(n_cases);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/slice_source.sv
// slice source: drives one matrix of slices on a valid/ready stream with random idle gaps
`timescale 1ns/100ps
`default_nettype none

module slice_source #(
    parameter int LFSR_SKIP = 0
) (
    input  logic                                               s_clk,
    input  logic                                               start,
    input  systolic_pkg::elem_t [systolic_pkg::MTRX_ELEMS-1:0] mtrx,
    output logic                                               idle,
    output logic                                               ready_timeout,
    // slice stream
    output logic                                               valid,
    output systolic_pkg::elem_t                                data,
    input  logic                                               ready
);

    import systolic_pkg::*;

    localparam int WAIT_LIMIT = 1000;

    logic [31:0] lfsr;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one beat, entered and left just after a rising edge
    task automatic send_beat(input elem_t value);
        int wait_cycles;
        wait_cycles = 0;
        lfsr = lfsr_step(lfsr);
        if (lfsr[0]) begin
            valid = 1'b0;
            @(posedge s_clk);
            #1;
        end
        valid = 1'b1;
        data  = value;
        // ready only moves on clock edges, so it is settled here
        while (!ready) begin
            @(posedge s_clk);
            #1;
            wait_cycles++;
            if (wait_cycles > WAIT_LIMIT) begin
                ready_timeout = 1'b1;
            end
        end
        @(posedge s_clk);
        #1;
    endtask

    initial begin
        valid         = 1'b0;
        data          = '0;
        idle          = 1'b1;
        ready_timeout = 1'b0;
        lfsr          = 32'ha3db_dd67;
        // each stream starts at its own point of the sequence
        repeat (LFSR_SKIP) lfsr = lfsr_step(lfsr);
        forever begin
            @(posedge s_clk);
            if (start) begin
                #1;
                idle = 1'b0;
                for (int k = 0; k < MTRX_ELEMS; k++) begin
                    send_beat(mtrx[k]);
                end
                valid = 1'b0;
                idle  = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mm_top.sv
// matrix-multiply engine top: two slice loaders, controller and systolic array
`timescale 1ns/100ps
`default_nettype none

module mm_top (
    input  logic                s_clk,
    input  logic                s_rst,
    // matrix A slices
    input  logic                a_valid,
    input  systolic_pkg::elem_t a_data,
    output logic                a_ready,
    // matrix B slices
    input  logic                b_valid,
    input  systolic_pkg::elem_t b_data,
    output logic                b_ready,
    // C results, row-major
    output logic                c_valid,
    output systolic_pkg::acc_t  c_data,
    input  logic                c_ready
);

    import systolic_pkg::*;

    logic                               a_full;
    logic                               b_full;
    logic                               a_release;
    logic                               b_release;
    elem_t [MTRX_ELEMS-1:0]             a_mtrx;
    elem_t [MTRX_ELEMS-1:0]             b_mtrx;
    logic                               clear;
    logic                               feed_en;
    elem_t [SYSTOLIC_UNIT_NUM-1:0]      a_edge;
    elem_t [SYSTOLIC_UNIT_NUM-1:0]      b_edge;
    idx_t                               sel_row;
    idx_t                               sel_col;
    acc_t                               sel_acc;

    slice_loader u_a_loader (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .slice_valid (a_valid),
        .slice_data  (a_data),
        .slice_ready (a_ready),
        .buf_release (a_release),
        .full        (a_full),
        .mtrx        (a_mtrx)
    );

    slice_loader u_b_loader (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .slice_valid (b_valid),
        .slice_data  (b_data),
        .slice_ready (b_ready),
        .buf_release (b_release),
        .full        (b_full),
        .mtrx        (b_mtrx)
    );

    mm_controller u_ctrl (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .a_full    (a_full),
        .b_full    (b_full),
        .a_mtrx    (a_mtrx),
        .b_mtrx    (b_mtrx),
        .a_release (a_release),
        .b_release (b_release),
        .clear     (clear),
        .feed_en   (feed_en),
        .a_edge    (a_edge),
        .b_edge    (b_edge),
        .sel_row   (sel_row),
        .sel_col   (sel_col),
        .sel_acc   (sel_acc),
        .c_valid   (c_valid),
        .c_data    (c_data),
        .c_ready   (c_ready)
    );

    systolic_array u_array (
        .s_clk   (s_clk),
        .s_rst   (s_rst),
        .clear   (clear),
        .feed_en (feed_en),
        .a_edge  (a_edge),
        .b_edge  (b_edge),
        .sel_row (sel_row),
        .sel_col (sel_col),
        .sel_acc (sel_acc)
    );

endmodule

`default_nettype wire

// File: rtl/mm_controller.sv
// matrix-multiply controller: skewed feed of both buffers, result drain and buffer release
`timescale 1ns/100ps
`default_nettype none

module mm_controller (
    input  logic                                                      s_clk,
    input  logic                                                      s_rst,
    // loader side
    input  logic                                                      a_full,
    input  logic                                                      b_full,
    input  systolic_pkg::elem_t [systolic_pkg::MTRX_ELEMS-1:0]        a_mtrx,
    input  systolic_pkg::elem_t [systolic_pkg::MTRX_ELEMS-1:0]        b_mtrx,
    output logic                                                      a_release,
    output logic                                                      b_release,
    // array side
    output logic                                                      clear,
    output logic                                                      feed_en,
    output systolic_pkg::elem_t [systolic_pkg::SYSTOLIC_UNIT_NUM-1:0] a_edge,
    output systolic_pkg::elem_t [systolic_pkg::SYSTOLIC_UNIT_NUM-1:0] b_edge,
    output systolic_pkg::idx_t                                        sel_row,
    output systolic_pkg::idx_t                                        sel_col,
    input  systolic_pkg::acc_t                                        sel_acc,
    // result stream
    output logic                                                      c_valid,
    output systolic_pkg::acc_t                                        c_data,
    input  logic                                                      c_ready
);

    import systolic_pkg::*;
    import mm_ctrl_pkg::*;

    mm_state_t state;
    mm_state_t state_nxt;
    step_t     step;
    beat_t     res_idx;
    logic      feed_last;
    logic      c_xfer;
    logic      drain_last;

    assign feed_last  = (state == FEED) && (step == step_t'(FEED_STEPS - 1));
    assign c_xfer     = c_valid && c_ready;
    assign drain_last = c_xfer && (res_idx == beat_t'(MTRX_ELEMS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (a_full && b_full) state_nxt = CLEAR;
            CLEAR:   state_nxt = FEED;
            FEED:    if (feed_last) state_nxt = DRAIN;
            DRAIN:   if (drain_last) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state   <= IDLE;
            step    <= '0;
            res_idx <= '0;
        end else begin
            state <= state_nxt;
            // step wraps to zero when the feed ends
            if (feed_last) begin
                step <= '0;
            end else if (state == FEED) begin
                step <= step + 1'b1;
            end
            // wraps to zero after the last result
            if (c_xfer) begin
                res_idx <= res_idx + 1'b1;
            end
        end
    end

    assign clear     = (state == CLEAR);
    assign feed_en   = (state == FEED);
    // buffers are no longer read once the feed is done
    assign a_release = feed_last;
    assign b_release = feed_last;

    // skew: row i gets A[i][step-i], column j gets B[step-j][j], zero outside the band
    always_comb begin
        int m;
        a_edge = '0;
        b_edge = '0;
        for (int i = 0; i < SYSTOLIC_UNIT_NUM; i++) begin
            m = int'(step) - i;
            if (state == FEED && m >= 0 && m < SYSTOLIC_UNIT_NUM) begin
                a_edge[i] = a_mtrx[i*SYSTOLIC_UNIT_NUM + m];
                b_edge[i] = b_mtrx[m*SYSTOLIC_UNIT_NUM + i];
            end
        end
    end

    // drain row-major
    assign sel_row = res_idx[3:2];
    assign sel_col = res_idx[1:0];
    assign c_valid = (state == DRAIN);
    assign c_data  = sel_acc;

    a_c_hold : assert property (
        @(posedge s_clk) disable iff (s_rst)
        c_valid && !c_ready |=> c_valid && $stable(c_data)
    ) else $error("mm_controller: result changed under back-pressure");

    // both buffers stay held while the edges read them
    a_feed_buffers_held : assert property (
        @(posedge s_clk) disable iff (s_rst)
        feed_en |-> a_full && b_full
    ) else $error("mm_controller: feed from a buffer that is not full");

endmodule

`default_nettype wire

// File: rtl/systolic_array.sv
// systolic array: 4 x 4 grid of MAC cells with accumulator clear and result select
`timescale 1ns/100ps
`default_nettype none

module systolic_array (
    input  logic                                                      s_clk,
    input  logic                                                      s_rst,
    input  logic                                                      clear,
    input  logic                                                      feed_en,
    // skewed operands, one per row on the left and one per column on top
    input  systolic_pkg::elem_t [systolic_pkg::SYSTOLIC_UNIT_NUM-1:0] a_edge,
    input  systolic_pkg::elem_t [systolic_pkg::SYSTOLIC_UNIT_NUM-1:0] b_edge,
    // result readout
    input  systolic_pkg::idx_t                                        sel_row,
    input  systolic_pkg::idx_t                                        sel_col,
    output systolic_pkg::acc_t                                        sel_acc
);

    import systolic_pkg::*;

    // a travels along a row, b down a column
    elem_t a_link   [SYSTOLIC_UNIT_NUM][SYSTOLIC_UNIT_NUM+1];
    elem_t b_link   [SYSTOLIC_UNIT_NUM+1][SYSTOLIC_UNIT_NUM];
    acc_t  acc_grid [SYSTOLIC_UNIT_NUM][SYSTOLIC_UNIT_NUM];

    genvar i;
    genvar j;

    generate
        // array edges
        for (i = 0; i < SYSTOLIC_UNIT_NUM; i++) begin : g_edge
            assign a_link[i][0] = a_edge[i];
            assign b_link[0][i] = b_edge[i];
        end

        for (i = 0; i < SYSTOLIC_UNIT_NUM; i++) begin : g_row
            for (j = 0; j < SYSTOLIC_UNIT_NUM; j++) begin : g_col
                systolic_pe u_pe (
                    .s_clk   (s_clk),
                    .s_rst   (s_rst),
                    .clear   (clear),
                    .feed_en (feed_en),
                    .a_in    (a_link[i][j]),
                    .b_in    (b_link[i][j]),
                    .a_out   (a_link[i][j+1]),
                    .b_out   (b_link[i+1][j]),
                    .acc     (acc_grid[i][j])
                );
            end
        end
    endgenerate

    // accumulators hold after the feed, so the select can walk them freely
    assign sel_acc = acc_grid[sel_row][sel_col];

    // clear would wipe a product mid-feed
    a_no_clear_in_feed : assert property (
        @(posedge s_clk) disable iff (s_rst)
        !(clear && feed_en)
    ) else $error("systolic_array: clear and feed_en high together");

endmodule

`default_nettype wire

// File: rtl/systolic_pe.sv
// systolic cell: signed multiply-accumulate, forwards operands right and down
`timescale 1ns/100ps
`default_nettype none

module systolic_pe (
    input  logic                s_clk,
    input  logic                s_rst,
    input  logic                clear,
    input  logic                feed_en,
    input  systolic_pkg::elem_t a_in,
    input  systolic_pkg::elem_t b_in,
    output systolic_pkg::elem_t a_out,
    output systolic_pkg::elem_t b_out,
    output systolic_pkg::acc_t  acc
);

    import systolic_pkg::*;

    logic signed [2*$bits(elem_t)-1:0] prod;

    assign prod = $signed(a_in) * $signed(b_in);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (clear) begin
            // also flush the operand pipeline so a new product starts clean
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (feed_en) begin
            acc   <= acc + {{($bits(acc_t) - $bits(prod)){prod[$bits(prod)-1]}}, prod};
            a_out <= a_in;
            b_out <= b_in;
        end
    end

endmodule

`default_nettype wire

// File: rtl/slice_loader.sv
// slice loader: buffers one matrix of valid/ready slices and holds it until released
`timescale 1ns/100ps
`default_nettype none

module slice_loader (
    input  logic                                               s_clk,
    input  logic                                               s_rst,
    // slice stream
    input  logic                                               slice_valid,
    input  systolic_pkg::elem_t                                slice_data,
    output logic                                               slice_ready,
    // buffer handoff to the controller
    input  logic                                               buf_release,
    output logic                                               full,
    output systolic_pkg::elem_t [systolic_pkg::MTRX_ELEMS-1:0] mtrx
);

    import systolic_pkg::*;

    beat_t wr_addr;
    logic  slice_xfer;

    // accept while the buffer has room
    assign slice_ready = !full;
    assign slice_xfer  = slice_valid && slice_ready;

    // write pointer and full flag
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_addr <= '0;
            full    <= 1'b0;
        end else if (buf_release) begin
            wr_addr <= '0;
            full    <= 1'b0;
        end else if (slice_xfer) begin
            wr_addr <= wr_addr + 1'b1;
            if (wr_addr == beat_t'(MTRX_ELEMS - 1)) begin
                full <= 1'b1;
            end
        end
    end

    // matrix storage, row-major by beat address
    always_ff @(posedge s_clk) begin
        if (slice_xfer) begin
            mtrx[wr_addr] <= slice_data;
        end
    end

    // controller only hands back a buffer it has consumed
    a_release_when_full : assert property (
        @(posedge s_clk) disable iff (s_rst)
        buf_release |-> full
    ) else $error("slice_loader: release while buffer not full");

endmodule

`default_nettype wire

// File: rtl/mm_ctrl_pkg.sv
// matrix-multiply controller package: feed sequencing constants and FSM encoding
`default_nettype none

package mm_ctrl_pkg;

    // skewed feed length, last product reaches the corner cell on the final step
    localparam int FEED_STEPS = 3 * systolic_pkg::SYSTOLIC_UNIT_NUM - 2;

    typedef logic [3:0] step_t;

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        FEED,
        DRAIN
    } mm_state_t;

endpackage

`default_nettype wire

// File: rtl/systolic_pkg.sv
// systolic array package: array dimensions and the element, accumulator and index types
`default_nettype none

package systolic_pkg;

    // rows and columns of the array
    localparam int SYSTOLIC_UNIT_NUM = 4;

    // slices in one matrix
    localparam int MTRX_ELEMS = SYSTOLIC_UNIT_NUM * SYSTOLIC_UNIT_NUM;

    // signed element, two's complement
    typedef logic [7:0] elem_t;

    // accumulated dot product, wide enough for 4 x (-128 x -128)
    typedef logic [31:0] acc_t;

    // element index inside a matrix, row in [3:2] and column in [1:0]
    typedef logic [3:0] beat_t;

    // row or column index
    typedef logic [1:0] idx_t;

endpackage

`default_nettype wire
